//--- rtl/rename_pkg.sv
////////////////////////////////////////
// Rename core shared definitions
// Register file sizes, ROB depth and the
// vector types used across the core
////////////////////////////////////////

package rename_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    // Architectural registers, x0 included
    localparam int arch_regs = 32;

    // Physical tags, first arch_regs of them mapped at reset
    localparam int phys_regs = 40;

    // In-flight instruction window
    localparam int rob_depth = 16;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    // Architectural register index
    typedef logic [$clog2(arch_regs)-1:0] arch_idx_t;

    // Physical tag
    typedef logic [$clog2(phys_regs)-1:0] phys_tag_t;

    // ROB slot index, wraps naturally
    typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;

    // ROB occupancy, 0 to rob_depth inclusive
    typedef logic [$clog2(rob_depth+1)-1:0] rob_count_t;

endpackage

//--- rtl/map_table.sv
////////////////////////////////////////
// Speculative rename map
// Two source lookups plus a destination
// read-and-replace per dispatch
////////////////////////////////////////

`timescale 1ns/1ps

module map_table import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  arch_idx_t rs1,
    input  arch_idx_t rs2,
    input  arch_idx_t rd,
    input  logic      write_en,
    input  phys_tag_t new_tag,
    output phys_tag_t src1_tag,
    output phys_tag_t src2_tag,
    output phys_tag_t old_tag
);

    // One tag per architectural register
    phys_tag_t map [arch_regs];

    // Lookups are purely combinational
    assign src1_tag = map[rs1];
    assign src2_tag = map[rs2];
    // Previous mapping of rd, kept by the ROB for freeing at commit
    assign old_tag  = map[rd];

    // Identity at reset, rename on writer dispatch
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < arch_regs; i++) begin
                map[i] <= phys_tag_t'(i);
            end
        end else if (write_en) begin
            map[rd] <= new_tag;
        end
    end

endmodule

//--- rtl/free_list.sv
////////////////////////////////////////
// Physical tag free list
// Bitmap with lowest-free-first grant
////////////////////////////////////////

`timescale 1ns/1ps

module free_list import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      alloc_en,
    input  logic      free_en,
    input  phys_tag_t free_tag,
    output phys_tag_t grant_tag,
    output logic      has_free
);

    // One bit per tag, set means available
    logic [phys_regs-1:0] free_bits;

    ////////////////////////////////////////
    // Grant select
    ////////////////////////////////////////

    // Scan downward so the lowest set bit wins
    always_comb begin
        grant_tag = '0;
        for (int i = phys_regs - 1; i >= 0; i--) begin
            if (free_bits[i]) begin
                grant_tag = phys_tag_t'(i);
            end
        end
    end

    assign has_free = |free_bits;

    ////////////////////////////////////////
    // Bitmap update
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // Tags above the identity map start free
            for (int i = 0; i < phys_regs; i++) begin
                free_bits[i] <= (i >= arch_regs);
            end
        end else begin
            // Granted tag leaves the pool
            if (alloc_en) begin
                free_bits[grant_tag] <= 1'b0;
            end
            // Committed tag returns, never the one just granted
            if (free_en) begin
                free_bits[free_tag] <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/reorder_buffer.sv
////////////////////////////////////////
// Reorder buffer
// Circular queue of in-flight entries,
// out-of-order completion marks and a
// head view for in-order retire
////////////////////////////////////////

`timescale 1ns/1ps

module reorder_buffer import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      alloc_en,
    input  arch_idx_t alloc_rd,
    input  logic      alloc_uses_rd,
    input  phys_tag_t alloc_dest_tag,
    input  phys_tag_t alloc_old_tag,
    output rob_idx_t  alloc_idx,
    output logic      full,
    input  logic      complete_en,
    input  rob_idx_t  complete_idx,
    output logic      head_valid,
    output logic      head_complete,
    output arch_idx_t head_rd,
    output logic      head_uses_rd,
    output phys_tag_t head_dest_tag,
    output phys_tag_t head_old_tag,
    input  logic      retire_en
);

    // Pointers and occupancy
    rob_idx_t   head;
    rob_idx_t   tail;
    rob_count_t count;

    // Per-entry completion flags
    logic [rob_depth-1:0] done;

    // Entry payload
    arch_idx_t rd_q       [rob_depth];
    logic      uses_rd_q  [rob_depth];
    phys_tag_t dest_tag_q [rob_depth];
    phys_tag_t old_tag_q  [rob_depth];

    ////////////////////////////////////////
    // Status and head view
    ////////////////////////////////////////

    assign alloc_idx     = tail;
    assign full          = (count == rob_count_t'(rob_depth));
    assign head_valid    = (count != '0);
    assign head_complete = done[head];
    assign head_rd       = rd_q[head];
    assign head_uses_rd  = uses_rd_q[head];
    assign head_dest_tag = dest_tag_q[head];
    assign head_old_tag  = old_tag_q[head];

    ////////////////////////////////////////
    // Control state
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            // Fresh entry starts incomplete
            if (alloc_en) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            // Completion names an occupied slot, never the one being written
            if (complete_en) begin
                done[complete_idx] <= 1'b1;
            end
            if (retire_en) begin
                head <= head + 1'b1;
            end
            // Net occupancy change
            case ({alloc_en, retire_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload written at the tail
    always_ff @(posedge clock) begin
        if (alloc_en) begin
            rd_q[tail]       <= alloc_rd;
            uses_rd_q[tail]  <= alloc_uses_rd;
            dest_tag_q[tail] <= alloc_dest_tag;
            old_tag_q[tail]  <= alloc_old_tag;
        end
    end

endmodule

//--- rtl/retire_unit.sv
////////////////////////////////////////
// Retire unit
// Commits the completed ROB head, keeps
// the committed map, frees old tags
////////////////////////////////////////

`timescale 1ns/1ps

module retire_unit import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      head_valid,
    input  logic      head_complete,
    input  arch_idx_t head_rd,
    input  logic      head_uses_rd,
    input  phys_tag_t head_dest_tag,
    input  phys_tag_t head_old_tag,
    output logic      retire_en,
    output logic      free_en,
    output phys_tag_t free_tag,
    output logic      commit_valid,
    output arch_idx_t commit_rd,
    output logic      commit_uses_rd,
    output phys_tag_t commit_dest_tag,
    output phys_tag_t commit_old_tag
);

    // Committed architectural map
    phys_tag_t arch_map [arch_regs];

    // One retire per cycle, whenever the head is done
    assign retire_en = head_valid & head_complete;

    // Only writers give a tag back
    assign free_en  = retire_en & head_uses_rd;
    // Committed mapping of rd is the tag being displaced
    assign free_tag = arch_map[head_rd];

    // Commit report
    assign commit_valid    = retire_en;
    assign commit_rd       = head_rd;
    assign commit_uses_rd  = head_uses_rd;
    assign commit_dest_tag = head_dest_tag;
    assign commit_old_tag  = head_old_tag;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < arch_regs; i++) begin
                arch_map[i] <= phys_tag_t'(i);
            end
        end else if (free_en) begin
            arch_map[head_rd] <= head_dest_tag;
        end
    end

endmodule

//--- rtl/rename_core.sv
////////////////////////////////////////
// Rename and commit core
// Map table, free list, ROB and retire
// for a one-wide dispatch stream
////////////////////////////////////////

`timescale 1ns/1ps

module rename_core import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    // Dispatch
    input  logic      dispatch_valid,
    output logic      dispatch_ready,
    input  arch_idx_t dispatch_rd,
    input  logic      dispatch_uses_rd,
    input  arch_idx_t dispatch_rs1,
    input  arch_idx_t dispatch_rs2,
    output rob_idx_t  dispatch_rob_idx,
    output phys_tag_t dispatch_src1_tag,
    output phys_tag_t dispatch_src2_tag,
    output phys_tag_t dispatch_dest_tag,
    // Completion from the execution side
    input  logic      complete_valid,
    input  rob_idx_t  complete_rob_idx,
    // Commit
    output logic      commit_valid,
    output arch_idx_t commit_rd,
    output logic      commit_uses_rd,
    output phys_tag_t commit_dest_tag,
    output phys_tag_t commit_old_tag
);

    logic      accept;
    logic      writer_alloc;
    phys_tag_t grant_tag;
    logic      has_free;
    phys_tag_t old_tag;
    logic      rob_full;
    logic      head_valid;
    logic      head_complete;
    arch_idx_t head_rd;
    logic      head_uses_rd;
    phys_tag_t head_dest_tag;
    phys_tag_t head_old_tag;
    logic      retire_en;
    logic      free_en;
    phys_tag_t free_tag;

    ////////////////////////////////////////
    // Dispatch handshake
    ////////////////////////////////////////

    // Needs a ROB slot and a spare tag, writer or not
    assign dispatch_ready    = ~rob_full & has_free;
    assign accept            = dispatch_valid & dispatch_ready;
    // Only writers consume a tag and rename rd
    assign writer_alloc      = accept & dispatch_uses_rd;
    assign dispatch_dest_tag = grant_tag;

    map_table u_map_table (
        .clock    (clock),
        .rst_n    (rst_n),
        .rs1      (dispatch_rs1),
        .rs2      (dispatch_rs2),
        .rd       (dispatch_rd),
        .write_en (writer_alloc),
        .new_tag  (grant_tag),
        .src1_tag (dispatch_src1_tag),
        .src2_tag (dispatch_src2_tag),
        .old_tag  (old_tag)
    );

    free_list u_free_list (
        .clock     (clock),
        .rst_n     (rst_n),
        .alloc_en  (writer_alloc),
        .free_en   (free_en),
        .free_tag  (free_tag),
        .grant_tag (grant_tag),
        .has_free  (has_free)
    );

    reorder_buffer u_reorder_buffer (
        .clock          (clock),
        .rst_n          (rst_n),
        .alloc_en       (accept),
        .alloc_rd       (dispatch_rd),
        .alloc_uses_rd  (dispatch_uses_rd),
        .alloc_dest_tag (grant_tag),
        .alloc_old_tag  (old_tag),
        .alloc_idx      (dispatch_rob_idx),
        .full           (rob_full),
        .complete_en    (complete_valid),
        .complete_idx   (complete_rob_idx),
        .head_valid     (head_valid),
        .head_complete  (head_complete),
        .head_rd        (head_rd),
        .head_uses_rd   (head_uses_rd),
        .head_dest_tag  (head_dest_tag),
        .head_old_tag   (head_old_tag),
        .retire_en      (retire_en)
    );

    // Commit path back to the free list
    retire_unit u_retire_unit (
        .clock           (clock),
        .rst_n           (rst_n),
        .head_valid      (head_valid),
        .head_complete   (head_complete),
        .head_rd         (head_rd),
        .head_uses_rd    (head_uses_rd),
        .head_dest_tag   (head_dest_tag),
        .head_old_tag    (head_old_tag),
        .retire_en       (retire_en),
        .free_en         (free_en),
        .free_tag        (free_tag),
        .commit_valid    (commit_valid),
        .commit_rd       (commit_rd),
        .commit_uses_rd  (commit_uses_rd),
        .commit_dest_tag (commit_dest_tag),
        .commit_old_tag  (commit_old_tag)
    );

endmodule

//--- test/rename_core_sva.sv
////////////////////////////////////////
// Rename core assertions
// Handshake and caller rules, bound
// into the core
////////////////////////////////////////

`timescale 1ns/1ps

module rename_core_sva import rename_pkg::*; (
    input logic                 clock,
    input logic                 rst_n,
    input logic                 dispatch_ready,
    input arch_idx_t            dispatch_rd,
    input logic                 dispatch_uses_rd,
    input logic                 complete_valid,
    input rob_idx_t             complete_rob_idx,
    input logic                 commit_valid,
    input rob_idx_t             rob_head,
    input rob_idx_t             rob_tail,
    input rob_count_t           rob_count,
    input logic [rob_depth-1:0] rob_done
);

    // Failed assertion count
    int assert_fails = 0;

    // Distance of the completed slot from the head
    rob_idx_t offset;
    assign offset = complete_rob_idx - rob_head;

    // Completion only for a live, unfinished entry
    complete_slot_live: assert property (@(posedge clock) disable iff (!rst_n)
        complete_valid |-> (offset < rob_count) && !rob_done[complete_rob_idx])
        else begin
            assert_fails++;
            $error("Completion named an empty or already complete ROB slot");
        end

    // x0 is never renamed
    no_x0_rename: assert property (@(posedge clock) disable iff (!rst_n)
        !(dispatch_uses_rd && dispatch_rd == '0))
        else begin
            assert_fails++;
            $error("Dispatch claimed a destination for register 0");
        end

    // Empty ROB right out of reset
    quiet_after_reset: assert property (@(posedge clock) $rose(rst_n) |-> !commit_valid)
        else begin
            assert_fails++;
            $error("Commit reported in the first cycle after reset");
        end

    // Tail only moves on an accepted dispatch
    hold_when_stalled: assert property (@(posedge clock) disable iff (!rst_n)
        !dispatch_ready |=> $stable(rob_tail))
        else begin
            assert_fails++;
            $error("Dispatch accepted while ready was low");
        end

endmodule

bind rename_core rename_core_sva u_sva (
    .clock            (clock),
    .rst_n            (rst_n),
    .dispatch_ready   (dispatch_ready),
    .dispatch_rd      (dispatch_rd),
    .dispatch_uses_rd (dispatch_uses_rd),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .commit_valid     (commit_valid),
    .rob_head         (u_reorder_buffer.head),
    .rob_tail         (u_reorder_buffer.tail),
    .rob_count        (u_reorder_buffer.count),
    .rob_done         (u_reorder_buffer.done)
);

//--- test/rename_core_tb.sv
////////////////////////////////////////
// Rename core testbench
// Table-driven directed phase, then an
// LFSR-driven random phase, all checked
// against reference models
////////////////////////////////////////

`timescale 1ns/1ps

module rename_core_tb import rename_pkg::*; ();

    localparam int period      = 20;
    localparam int rand_cycles = 200;

    typedef enum logic [1:0] {op_idle, op_disp, op_comp} op_t;

    // One table row, repeated reps times with rd and cidx stepping by one
    typedef struct packed {
        op_t       op;
        arch_idx_t rd;
        logic      uses;
        arch_idx_t rs1;
        arch_idx_t rs2;
        rob_idx_t  cidx;
        logic [4:0] reps;
        logic      ready;
    } row_t;

    typedef struct packed {
        rob_idx_t  idx;
        arch_idx_t rd;
        logic      uses;
        phys_tag_t dest;
        phys_tag_t old;
    } rob_entry_t;

    //  op       rd     uses  rs1    rs2    cidx   reps   ready
    row_t table_rows [27] = '{
        '{op_idle, 5'd0,  1'b0, 5'd5,  5'd7,  4'd0,  5'd1,  1'b1},
        '{op_disp, 5'd1,  1'b1, 5'd2,  5'd3,  4'd0,  5'd1,  1'b1},
        '{op_disp, 5'd2,  1'b1, 5'd1,  5'd1,  4'd0,  5'd1,  1'b1},
        '{op_disp, 5'd0,  1'b0, 5'd2,  5'd1,  4'd0,  5'd1,  1'b1},
        '{op_disp, 5'd1,  1'b1, 5'd1,  5'd2,  4'd0,  5'd1,  1'b1},
        '{op_disp, 5'd3,  1'b1, 5'd1,  5'd4,  4'd0,  5'd1,  1'b1},
        // Out-of-order completion with in-order commit
        '{op_comp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd3,  5'd1,  1'b1},
        '{op_comp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd1,  5'd1,  1'b1},
        '{op_comp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd4,  5'd1,  1'b1},
        '{op_comp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd2,  5'd1,  1'b1},
        '{op_comp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd0,  5'd1,  1'b1},
        '{op_idle, 5'd0,  1'b0, 5'd0,  5'd0,  4'd0,  5'd5,  1'b1},
        // Eight writers drain the free list and the first reuses tag 1
        '{op_disp, 5'd4,  1'b1, 5'd1,  5'd3,  4'd0,  5'd8,  1'b1},
        '{op_disp, 5'd12, 1'b1, 5'd4,  5'd12, 4'd0,  5'd1,  1'b0},
        '{op_comp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd5,  5'd1,  1'b0},
        '{op_idle, 5'd0,  1'b0, 5'd0,  5'd0,  4'd0,  5'd1,  1'b0},
        '{op_disp, 5'd12, 1'b1, 5'd4,  5'd12, 4'd0,  5'd1,  1'b1},
        '{op_comp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd7,  5'd7,  1'b0},
        '{op_comp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd6,  5'd1,  1'b0},
        '{op_idle, 5'd0,  1'b0, 5'd0,  5'd0,  4'd0,  5'd1,  1'b0},
        '{op_idle, 5'd0,  1'b0, 5'd0,  5'd0,  4'd0,  5'd8,  1'b1},
        // Sixteen non-writers fill the ROB
        '{op_disp, 5'd16, 1'b0, 5'd13, 5'd14, 4'd0,  5'd16, 1'b1},
        '{op_disp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd0,  5'd1,  1'b0},
        '{op_comp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd14, 5'd1,  1'b0},
        '{op_idle, 5'd0,  1'b0, 5'd0,  5'd0,  4'd0,  5'd1,  1'b0},
        '{op_comp, 5'd0,  1'b0, 5'd0,  5'd0,  4'd15, 5'd15, 1'b1},
        '{op_idle, 5'd0,  1'b0, 5'd0,  5'd0,  4'd0,  5'd3,  1'b1}
    };

    logic      clock;
    logic      rst_n;
    logic      dispatch_valid;
    logic      dispatch_ready;
    arch_idx_t dispatch_rd;
    logic      dispatch_uses_rd;
    arch_idx_t dispatch_rs1;
    arch_idx_t dispatch_rs2;
    rob_idx_t  dispatch_rob_idx;
    phys_tag_t dispatch_src1_tag;
    phys_tag_t dispatch_src2_tag;
    phys_tag_t dispatch_dest_tag;
    logic      complete_valid;
    rob_idx_t  complete_rob_idx;
    logic      commit_valid;
    arch_idx_t commit_rd;
    logic      commit_uses_rd;
    phys_tag_t commit_dest_tag;
    phys_tag_t commit_old_tag;

    // Reference models
    phys_tag_t            map_m  [arch_regs];
    phys_tag_t            arch_m [arch_regs];
    logic [phys_regs-1:0] free_m;
    logic [rob_depth-1:0] done_m;
    rob_entry_t           rob_q [$];
    rob_idx_t             tail_m;
    logic [15:0]          lfsr_state;
    int                   error_count;

    rename_core UUT (.*);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    ////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////

    task automatic report_failure();
        error_count++;
        $display("Test failures found");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic check_tag(input string name, input phys_tag_t got, input phys_tag_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_reg(input string name, input arch_idx_t got, input arch_idx_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    // Ascending search so the first free tag wins
    function automatic phys_tag_t lowest_free();
        for (int t = 0; t < phys_regs; t++) begin
            if (free_m[t]) begin
                return phys_tag_t'(t);
            end
        end
        return '0;
    endfunction

    // 16-bit Galois LFSR stepped once per bit taken
    function automatic int draw(input int nbits);
        int value;
        value = 0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    ////////////////////////////////////////
    // One clock cycle
    ////////////////////////////////////////

    task automatic run_cycle(input logic dv, input arch_idx_t rd, input logic uses,
                             input arch_idx_t rs1, input arch_idx_t rs2,
                             input logic cv, input rob_idx_t cidx);
        rob_entry_t oldest;
        rob_entry_t fresh;
        logic       ready_m;
        phys_tag_t  grant_m;
        @(posedge clock);
        #2;
        dispatch_valid   = dv;
        dispatch_rd      = rd;
        dispatch_uses_rd = uses;
        dispatch_rs1     = rs1;
        dispatch_rs2     = rs2;
        complete_valid   = cv;
        complete_rob_idx = cidx;
        // Outputs settled mid-cycle
        @(negedge clock);
        ready_m = (rob_q.size() < rob_depth) && (free_m != '0);
        grant_m = lowest_free();
        check_bit("dispatch_ready", dispatch_ready, ready_m);
        check_tag("dispatch_src1_tag", dispatch_src1_tag, map_m[rs1]);
        check_tag("dispatch_src2_tag", dispatch_src2_tag, map_m[rs2]);
        // Head retires when complete
        if (rob_q.size() > 0 && done_m[rob_q[0].idx]) begin
            oldest = rob_q.pop_front();
            check_bit("commit_valid", commit_valid, 1'b1);
            check_reg("commit_rd", commit_rd, oldest.rd);
            check_bit("commit_uses_rd", commit_uses_rd, oldest.uses);
            if (oldest.uses) begin
                check_tag("commit_dest_tag", commit_dest_tag, oldest.dest);
                check_tag("commit_old_tag", commit_old_tag, oldest.old);
                free_m[arch_m[oldest.rd]] = 1'b1;
                arch_m[oldest.rd] = oldest.dest;
            end
        end else begin
            check_bit("commit_valid", commit_valid, 1'b0);
        end
        // Accepted dispatch enters the models
        if (dv && ready_m) begin
            check_idx("dispatch_rob_idx", dispatch_rob_idx, tail_m);
            fresh.idx  = tail_m;
            fresh.rd   = rd;
            fresh.uses = uses;
            fresh.dest = grant_m;
            fresh.old  = map_m[rd];
            if (uses) begin
                check_tag("dispatch_dest_tag", dispatch_dest_tag, grant_m);
                free_m[grant_m] = 1'b0;
                map_m[rd] = grant_m;
            end
            rob_q.push_back(fresh);
            done_m[tail_m] = 1'b0;
            tail_m = tail_m + 1'b1;
        end
        if (cv) begin
            done_m[cidx] = 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        row_t      row;
        logic      dv;
        logic      cv;
        arch_idx_t rd;
        arch_idx_t rs1;
        arch_idx_t rs2;
        rob_idx_t  cidx;
        int        pick;
        rob_idx_t  pending [$];
        rst_n            = 1'b0;
        dispatch_valid   = 1'b0;
        dispatch_rd      = '0;
        dispatch_uses_rd = 1'b0;
        dispatch_rs1     = '0;
        dispatch_rs2     = '0;
        complete_valid   = 1'b0;
        complete_rob_idx = '0;
        error_count      = 0;
        lfsr_state       = 16'd14;
        tail_m           = '0;
        done_m           = '0;
        // Identity maps with the upper tags free
        for (int i = 0; i < arch_regs; i++) begin
            map_m[i]  = phys_tag_t'(i);
            arch_m[i] = phys_tag_t'(i);
        end
        for (int t = 0; t < phys_regs; t++) begin
            free_m[t] = (t >= arch_regs);
        end
        repeat (3) @(posedge clock);
        #2;
        rst_n = 1'b1;

        // Directed table
        for (int r = 0; r < $size(table_rows); r++) begin
            row = table_rows[r];
            for (int i = 0; i < row.reps; i++) begin
                run_cycle(row.op == op_disp, arch_idx_t'(row.rd + i), row.uses,
                          row.rs1, row.rs2, row.op == op_comp, rob_idx_t'(row.cidx + i));
                check_bit("dispatch_ready", dispatch_ready, row.ready);
            end
        end

        // Random traffic with completion picked among pending slots
        for (int n = 0; n < rand_cycles; n++) begin
            dv   = 1'(draw(1));
            rd   = arch_idx_t'(draw(5));
            rs1  = arch_idx_t'(draw(5));
            rs2  = arch_idx_t'(draw(5));
            cv   = 1'(draw(1));
            pick = draw(4);
            pending.delete();
            foreach (rob_q[k]) begin
                if (!done_m[rob_q[k].idx]) begin
                    pending.push_back(rob_q[k].idx);
                end
            end
            if (pending.size() == 0) begin
                cv   = 1'b0;
                cidx = '0;
            end else begin
                cidx = pending[pick % pending.size()];
            end
            run_cycle(dv, rd, rd != '0, rs1, rs2, cv, cidx);
        end

        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Bound checker failures
    initial begin
        wait (UUT.u_sva.assert_fails != 0);
        $display("A bound assertion on the rename core failed");
        report_failure();
    end

    // Watchdog allows four clocks per stimulus cycle
    initial begin
        int limit;
        limit = 3 + rand_cycles;
        foreach (table_rows[r]) begin
            limit += int'(table_rows[r].reps);
        end
        repeat (limit * 4) @(posedge clock);
        $display("Simulation ran past its cycle budget without finishing");
        $display("Test failures found");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- filelist.f
rtl/rename_pkg.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/reorder_buffer.sv
rtl/retire_unit.sv
rtl/rename_core.sv
test/rename_core_sva.sv
test/rename_core_tb.sv
